//--- tb.f
source/axi_pkg.sv
source/axi_arbiter.sv
source/axi_sram.sv
source/mem_subsys_top.sv
dv/mem_checker.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the run passes only if the pass message shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim &&
out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -q "All tests passed!" && exit 0 || exit 1

//--- dv/tb_top.sv
// testbench top with clock, reset, DUT and checker instances
// stimulus for six tests and the watchdog

`timescale 1ns/10ps
`default_nettype none

module tb_top;

	import axi_pkg::*;

	localparam int RST_CYCLES = 8;
	localparam int TXN_BOUND  = 20;  // cycles allowed per transaction
	localparam int TXN_TOTAL  = 368; // summed over all tests

	logic clk = 1'b0;
	logic rst = 1'b1;

	// DUT port signals
	axi_addr_t  inst_ar_i = '0;
	axi_addr_t  data_ar_i = '0;
	axi_addr_t  data_aw_i = '0;
	axi_wdata_t data_w_i = '0;
	logic       inst_ar_valid_i = 1'b0;
	logic       data_ar_valid_i = 1'b0;
	logic       data_aw_valid_i = 1'b0;
	logic       data_w_valid_i = 1'b0;
	logic       inst_r_ready_i = 1'b1;
	logic       data_r_ready_i = 1'b1;
	logic       data_b_ready_i = 1'b1;
	axi_rdata_t inst_r_o, data_r_o;
	axi_bresp_t data_b_o;
	logic       inst_ar_ready_o, inst_r_valid_o, data_ar_ready_o, data_r_valid_o;
	logic       data_aw_ready_o, data_w_ready_o, data_b_valid_o;

	logic [8*16-1:0] test_name = "reset";
	logic            test_done = 1'b0;
	logic            run_done = 1'b0;
	logic            bp_en = 1'b0; // random ready back-pressure
	int              err_count;
	int              kind;
	logic [ADDR_W-1:0] addr;

	mem_subsys_top uut (.*);

	mem_checker chk (
		.*,
		.test_name_i   (test_name),
		.test_done_i   (test_done),
		.run_done_i    (run_done),
		.error_count_o (err_count)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		inst_r_ready_i <= bp_en ? (($urandom % 4) != 0) : 1'b1;
		data_r_ready_i <= bp_en ? (($urandom % 4) != 0) : 1'b1;
		data_b_ready_i <= bp_en ? (($urandom % 4) != 0) : 1'b1;
	end

	// raise the chosen requests together and follow them until every response is taken
	task automatic run_txn(
		input logic do_inst, do_rd, do_wr,
		input logic [ADDR_W-1:0] iaddr, raddr, waddr,
		input logic [DATA_W-1:0] wdata,
		input logic [STRB_W-1:0] wstrb
	);
		int   left;
		logic i_acc, r_acc, w_acc, got;
		left = int'(do_inst) + int'(do_rd) + int'(do_wr);
		@(posedge clk);
		inst_ar_i.addr  <= iaddr;
		inst_ar_valid_i <= do_inst;
		data_ar_i.addr  <= raddr;
		data_ar_valid_i <= do_rd;
		data_aw_i.addr  <= waddr;
		data_w_i.data   <= wdata;
		data_w_i.strb   <= wstrb;
		data_aw_valid_i <= do_wr;
		data_w_valid_i  <= do_wr;
		while (left > 0) begin
			@(negedge clk);
			i_acc = inst_ar_valid_i && inst_ar_ready_o;
			r_acc = data_ar_valid_i && data_ar_ready_o;
			w_acc = data_aw_valid_i && data_aw_ready_o;
			got = (inst_r_valid_o && inst_r_ready_i) || (data_r_valid_o && data_r_ready_i)
				|| (data_b_valid_o && data_b_ready_i);
			@(posedge clk);
			if (i_acc)
				inst_ar_valid_i <= 1'b0;
			if (r_acc)
				data_ar_valid_i <= 1'b0;
			if (w_acc) begin
				data_aw_valid_i <= 1'b0;
				data_w_valid_i  <= 1'b0;
			end
			if (got)
				left--;
		end
	endtask

	task automatic data_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
		input logic [STRB_W-1:0] s);
		run_txn(1'b0, 1'b0, 1'b1, '0, '0, a, d, s);
	endtask

	task automatic data_read(input logic [ADDR_W-1:0] a);
		run_txn(1'b0, 1'b1, 1'b0, '0, a, '0, '0, '0);
	endtask

	task automatic inst_read(input logic [ADDR_W-1:0] a);
		run_txn(1'b1, 1'b0, 1'b0, a, '0, '0, '0, '0);
	endtask

	task automatic end_test();
		@(posedge clk);
		test_done <= 1'b1;
		@(posedge clk);
		test_done <= 1'b0;
	endtask

	initial begin
		void'($urandom(86));
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;

		test_name <= "full_write_read";
		for (int i = 0; i < MEM_DEPTH; i++)
			data_write(i * 4, $urandom, 4'hf);
		for (int i = 0; i < MEM_DEPTH; i++)
			data_read(i * 4);
		end_test();

		test_name <= "partial_strobe";
		for (int i = 0; i < 8; i++)
			data_write((i * 9 % MEM_DEPTH) * 4, $urandom, STRB_W'(i * 3 + 1));
		for (int i = 0; i < 8; i++)
			data_read((i * 9 % MEM_DEPTH) * 4);
		end_test();

		test_name <= "inst_fetch";
		for (int i = 0; i < 8; i++)
			inst_read((i * 7 + 3) * 4);
		end_test();

		test_name <= "priority";
		run_txn(1'b1, 1'b1, 1'b0, 32'h10, 32'h20, '0, '0, '0);
		run_txn(1'b1, 1'b0, 1'b1, 32'h14, '0, 32'h24, 32'hcafe_f00d, 4'hf);
		run_txn(1'b0, 1'b1, 1'b1, '0, 32'h28, 32'h28, 32'h1234_5678, 4'hf); // read sees new word
		run_txn(1'b1, 1'b1, 1'b1, 32'h2c, 32'h2c, 32'h2c, 32'h0bad_beef, 4'h3);
		end_test();

		test_name <= "out_of_range";
		data_read(MEM_DEPTH * 4);
		data_write(32'h0000_1000, 32'hdead_beef, 4'hf); // would alias word 0
		data_write(32'h0000_0104, 32'hdead_beef, 4'hf); // word 65 would alias word 1
		inst_read(32'hffff_fffc);
		data_read(32'h0);
		data_read(32'h4);
		inst_read(32'h4);
		end_test();

		test_name <= "random_mixed";
		bp_en <= 1'b1;
		for (int n = 0; n < 200; n++) begin
			kind = $urandom % 3;
			addr = ($urandom % (MEM_DEPTH + 8)) * 4; // some past the end
			case (kind)
				0: inst_read(addr);
				1: data_read(addr);
				default: data_write(addr, $urandom, STRB_W'($urandom));
			endcase
		end
		bp_en <= 1'b0;
		end_test();

		run_done <= 1'b1;
		repeat (2) @(posedge clk);
		if (err_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog sized from the transaction count
	initial begin
		repeat (RST_CYCLES + TXN_TOTAL * TXN_BOUND) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles",
			RST_CYCLES + TXN_TOTAL * TXN_BOUND);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/mem_checker.sv
// response checker with a reference memory model and expected-response function
// grant order, latency and port routing checks, per-test lines and final counts

`timescale 1ns/10ps
`default_nettype none

module mem_checker (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic [8*16-1:0] test_name_i,
	input  wire logic            test_done_i,
	input  wire logic            run_done_i,
	input  axi_pkg::axi_addr_t   inst_ar_i, data_ar_i, data_aw_i,
	input  axi_pkg::axi_wdata_t  data_w_i,
	input  axi_pkg::axi_rdata_t  inst_r_o, data_r_o,
	input  axi_pkg::axi_bresp_t  data_b_o,
	input  wire logic            inst_ar_valid_i, inst_ar_ready_o, inst_r_valid_o, inst_r_ready_i,
	input  wire logic            data_ar_valid_i, data_ar_ready_o, data_r_valid_o, data_r_ready_i,
	input  wire logic            data_aw_valid_i, data_aw_ready_o, data_w_valid_i, data_w_ready_o,
	input  wire logic            data_b_valid_o, data_b_ready_i,
	output int                   error_count_o
);

	import axi_pkg::*;

	typedef enum logic [1:0] {
		NONE,
		DATA_RD,
		DATA_WR,
		INST_RD
	} kind_t;

	logic [DATA_W-1:0] model [MEM_DEPTH];
	logic [IDX_W-1:0]  widx;
	kind_t             pend = NONE; // transaction in flight
	axi_rdata_t        exp_r;
	logic [1:0]        exp_b;
	logic              resp_seen = 1'b0;
	logic              pend_valid;
	logic              summary_done = 1'b0;
	int                cyc = 0;
	int                acc_cyc = 0;
	int                checks = 0;
	int                errors = 0;
	int                test_checks = 0;
	int                test_errors = 0;

	assign error_count_o = errors;

	function automatic logic in_range(input logic [ADDR_W-1:0] addr);
		return (addr >> 2) < ADDR_W'(MEM_DEPTH);
	endfunction

	// strobed bytes replace the old ones, the rest of the word stays
	function automatic logic [DATA_W-1:0] merge_bytes(
		input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w,
		input logic [STRB_W-1:0] strb
	);
		logic [DATA_W-1:0] res;
		res = old_w;
		for (int i = 0; i < STRB_W; i++) begin
			if (strb[i])
				res[8*i +: 8] = new_w[8*i +: 8];
		end
		return res;
	endfunction

	// zero data and SLVERR past the last word
	function automatic axi_rdata_t expected_read(input logic [ADDR_W-1:0] addr);
		axi_rdata_t r;
		r.data = in_range(addr) ? model[addr[IDX_W+1:2]] : '0;
		r.resp = in_range(addr) ? RESP_OKAY : RESP_SLVERR;
		return r;
	endfunction

	task automatic flag_error(input string msg);
		$display("ERROR in %0s: %0s", test_name_i, msg);
		errors++;
		test_errors++;
	endtask

	task automatic compare_resp(input string chan, input logic [DATA_W-1:0] exp_d,
		input logic [1:0] exp_s, input logic [DATA_W-1:0] act_d, input logic [1:0] act_s);
		checks++;
		test_checks++;
		if (exp_d !== act_d || exp_s !== act_s) begin
			$display("FAIL %0s %0s: expected %h resp %0d, actual %h resp %0d",
				test_name_i, chan, exp_d, exp_s, act_d, act_s);
			errors++;
			test_errors++;
		end
	endtask

	task automatic start_txn(input kind_t kind);
		pend = kind;
		acc_cyc = cyc;
		resp_seen = 1'b0;
	endtask

	// sampled mid-cycle, so every value here is what the next rising edge sees
	always @(negedge clk) begin
		cyc++;
		if (!rst) begin
			if (pend != NONE && (inst_ar_ready_o || data_ar_ready_o || data_aw_ready_o))
				flag_error("an address ready was high while a transaction was outstanding");
			if (inst_ar_ready_o && (data_ar_valid_i || (data_aw_valid_i && data_w_valid_i)))
				flag_error("instruction fetch was granted ahead of a data request");
			if (data_ar_ready_o && data_aw_valid_i && data_w_valid_i)
				flag_error("data read was granted ahead of a data write");
			if ((data_aw_valid_i && data_aw_ready_o) != (data_w_valid_i && data_w_ready_o))
				flag_error("write address and write data were not accepted together");
			if (inst_r_valid_o && pend != INST_RD)
				flag_error("read data reached the instruction port with no fetch in flight");
			if (data_r_valid_o && pend != DATA_RD)
				flag_error("read data reached the data port with no data read in flight");
			if (data_b_valid_o && pend != DATA_WR)
				flag_error("write response arrived with no data write in flight");

			case (pend)
				INST_RD: pend_valid = inst_r_valid_o;
				DATA_RD: pend_valid = data_r_valid_o;
				DATA_WR: pend_valid = data_b_valid_o;
				default: pend_valid = 1'b0;
			endcase
			if (pend != NONE && !resp_seen && cyc == acc_cyc + 1) begin
				resp_seen = 1'b1;
				if (!pend_valid)
					flag_error("response valid did not rise one cycle after the address handshake");
			end

			if (pend == INST_RD && inst_r_valid_o && inst_r_ready_i) begin
				compare_resp("inst read", exp_r.data, exp_r.resp, inst_r_o.data, inst_r_o.resp);
				pend = NONE;
			end
			if (pend == DATA_RD && data_r_valid_o && data_r_ready_i) begin
				compare_resp("data read", exp_r.data, exp_r.resp, data_r_o.data, data_r_o.resp);
				pend = NONE;
			end
			if (pend == DATA_WR && data_b_valid_o && data_b_ready_i) begin
				compare_resp("data write", '0, exp_b, '0, data_b_o.resp);
				pend = NONE;
			end

			// model follows each accepted write
			if (data_aw_valid_i && data_aw_ready_o) begin
				exp_b = in_range(data_aw_i.addr) ? RESP_OKAY : RESP_SLVERR;
				widx = data_aw_i.addr[IDX_W+1:2];
				if (in_range(data_aw_i.addr))
					model[widx] = merge_bytes(model[widx], data_w_i.data, data_w_i.strb);
				start_txn(DATA_WR);
			end
			if (data_ar_valid_i && data_ar_ready_o) begin
				exp_r = expected_read(data_ar_i.addr);
				start_txn(DATA_RD);
			end
			if (inst_ar_valid_i && inst_ar_ready_o) begin
				exp_r = expected_read(inst_ar_i.addr);
				start_txn(INST_RD);
			end
		end

		if (test_done_i) begin
			$display("test %0s: %0d checks, %0d errors", test_name_i, test_checks, test_errors);
			test_checks = 0;
			test_errors = 0;
		end
		if (run_done_i && !summary_done) begin
			if (pend != NONE)
				flag_error("a transaction was still outstanding at the end of the run");
			$display("total: %0d checks, %0d errors", checks, errors);
			summary_done = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/mem_subsys_top.sv
// memory subsystem top, arbiter in front of the word memory
// exposes the instruction and data master ports

`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top (
	input  wire logic               clk,
	input  wire logic               rst,

	input  axi_pkg::axi_addr_t      inst_ar_i,
	input  wire logic               inst_ar_valid_i,
	output logic                    inst_ar_ready_o,
	output axi_pkg::axi_rdata_t     inst_r_o,
	output logic                    inst_r_valid_o,
	input  wire logic               inst_r_ready_i,

	input  axi_pkg::axi_addr_t      data_ar_i,
	input  wire logic               data_ar_valid_i,
	output logic                    data_ar_ready_o,
	input  axi_pkg::axi_addr_t      data_aw_i,
	input  wire logic               data_aw_valid_i,
	output logic                    data_aw_ready_o,
	input  axi_pkg::axi_wdata_t     data_w_i,
	input  wire logic               data_w_valid_i,
	output logic                    data_w_ready_o,
	output axi_pkg::axi_rdata_t     data_r_o,
	output logic                    data_r_valid_o,
	input  wire logic               data_r_ready_i,
	output axi_pkg::axi_bresp_t     data_b_o,
	output logic                    data_b_valid_o,
	input  wire logic               data_b_ready_i
);

	import axi_pkg::*;

	// slave side channels
	axi_addr_t  mem_ar;
	axi_addr_t  mem_aw;
	axi_wdata_t mem_w;
	axi_rdata_t mem_r;
	axi_bresp_t mem_b;
	logic       mem_ar_valid, mem_ar_ready;
	logic       mem_aw_valid, mem_aw_ready;
	logic       mem_w_valid, mem_w_ready;
	logic       mem_r_valid, mem_r_ready;
	logic       mem_b_valid, mem_b_ready;

	axi_arbiter u_arbiter (
		.clk             (clk),
		.rst             (rst),
		.inst_ar_i       (inst_ar_i),
		.inst_ar_valid_i (inst_ar_valid_i),
		.inst_ar_ready_o (inst_ar_ready_o),
		.inst_r_o        (inst_r_o),
		.inst_r_valid_o  (inst_r_valid_o),
		.inst_r_ready_i  (inst_r_ready_i),
		.data_ar_i       (data_ar_i),
		.data_ar_valid_i (data_ar_valid_i),
		.data_ar_ready_o (data_ar_ready_o),
		.data_aw_i       (data_aw_i),
		.data_aw_valid_i (data_aw_valid_i),
		.data_aw_ready_o (data_aw_ready_o),
		.data_w_i        (data_w_i),
		.data_w_valid_i  (data_w_valid_i),
		.data_w_ready_o  (data_w_ready_o),
		.data_r_o        (data_r_o),
		.data_r_valid_o  (data_r_valid_o),
		.data_r_ready_i  (data_r_ready_i),
		.data_b_o        (data_b_o),
		.data_b_valid_o  (data_b_valid_o),
		.data_b_ready_i  (data_b_ready_i),
		.mem_ar_o        (mem_ar),
		.mem_ar_valid_o  (mem_ar_valid),
		.mem_ar_ready_i  (mem_ar_ready),
		.mem_aw_o        (mem_aw),
		.mem_aw_valid_o  (mem_aw_valid),
		.mem_aw_ready_i  (mem_aw_ready),
		.mem_w_o         (mem_w),
		.mem_w_valid_o   (mem_w_valid),
		.mem_w_ready_i   (mem_w_ready),
		.mem_r_i         (mem_r),
		.mem_r_valid_i   (mem_r_valid),
		.mem_r_ready_o   (mem_r_ready),
		.mem_b_i         (mem_b),
		.mem_b_valid_i   (mem_b_valid),
		.mem_b_ready_o   (mem_b_ready)
	);

	axi_sram u_sram (
		.clk        (clk),
		.rst        (rst),
		.ar_i       (mem_ar),
		.ar_valid_i (mem_ar_valid),
		.ar_ready_o (mem_ar_ready),
		.aw_i       (mem_aw),
		.aw_valid_i (mem_aw_valid),
		.aw_ready_o (mem_aw_ready),
		.w_i        (mem_w),
		.w_valid_i  (mem_w_valid),
		.w_ready_o  (mem_w_ready),
		.r_o        (mem_r),
		.r_valid_o  (mem_r_valid),
		.r_ready_i  (mem_r_ready),
		.b_o        (mem_b),
		.b_valid_o  (mem_b_valid),
		.b_ready_i  (mem_b_ready)
	);

endmodule

`default_nettype wire

//--- source/axi_sram.sv
// AXI-lite word memory with byte strobes
// out-of-range accesses answer SLVERR and leave the array alone

`timescale 1ns/10ps
`default_nettype none

module axi_sram (
	input  wire logic               clk,
	input  wire logic               rst,

	input  axi_pkg::axi_addr_t      ar_i,
	input  wire logic               ar_valid_i,
	output logic                    ar_ready_o,

	input  axi_pkg::axi_addr_t      aw_i,
	input  wire logic               aw_valid_i,
	output logic                    aw_ready_o,

	input  axi_pkg::axi_wdata_t     w_i,
	input  wire logic               w_valid_i,
	output logic                    w_ready_o,

	output axi_pkg::axi_rdata_t     r_o,
	output logic                    r_valid_o,
	input  wire logic               r_ready_i,

	output axi_pkg::axi_bresp_t     b_o,
	output logic                    b_valid_o,
	input  wire logic               b_ready_i
);

	import axi_pkg::*;

	logic [DATA_W-1:0] mem_q [MEM_DEPTH];

	axi_rdata_t r_q;
	axi_bresp_t b_q;
	logic       r_valid_q;
	logic       b_valid_q;

	logic              pending;
	logic              rd_fire;
	logic              wr_fire;
	logic [ADDR_W-3:0] rd_word; // byte address without low two bits
	logic [ADDR_W-3:0] wr_word;
	logic [IDX_W-1:0]  rd_idx;
	logic [IDX_W-1:0]  wr_idx;
	logic              rd_in_range;
	logic              wr_in_range;

	assign pending = r_valid_q | b_valid_q;

	assign ar_ready_o = ~pending;
	assign aw_ready_o = ~pending;
	assign w_ready_o  = ~pending;

	assign rd_fire = ar_valid_i & ~pending;
	assign wr_fire = aw_valid_i & w_valid_i & ~pending; // address and data together

	assign rd_word     = ar_i.addr[ADDR_W-1:2];
	assign wr_word     = aw_i.addr[ADDR_W-1:2];
	assign rd_idx      = rd_word[IDX_W-1:0];
	assign wr_idx      = wr_word[IDX_W-1:0];
	assign rd_in_range = (rd_word < MEM_DEPTH);
	assign wr_in_range = (wr_word < MEM_DEPTH);

	// strobed byte merge on the accepting edge
	always_ff @(posedge clk) begin
		if (wr_fire && wr_in_range) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (w_i.strb[i])
					mem_q[wr_idx][8*i +: 8] <= w_i.data[8*i +: 8];
			end
		end
	end

	// response payloads
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			r_q.data <= rd_in_range ? mem_q[rd_idx] : '0;
			r_q.resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
		end
		if (wr_fire)
			b_q.resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (rd_fire)
				r_valid_q <= 1'b1; // one cycle after the address
			else if (r_ready_i)
				r_valid_q <= 1'b0;

			if (wr_fire)
				b_valid_q <= 1'b1;
			else if (b_ready_i)
				b_valid_q <= 1'b0;
		end
	end

	assign r_o       = r_q;
	assign r_valid_o = r_valid_q;
	assign b_o       = b_q;
	assign b_valid_o = b_valid_q;

	// a response holds until the master takes it
	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		r_valid_o && !r_ready_i |=> r_valid_o);

	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		b_valid_o && !b_ready_i |=> b_valid_o);

endmodule

`default_nettype wire

//--- source/axi_arbiter.sv
// fixed-priority arbiter, data port over instruction fetch
// data write beats data read, one transaction in flight at a time

`timescale 1ns/10ps
`default_nettype none

module axi_arbiter (
	input  wire logic               clk,
	input  wire logic               rst,

	// instruction master
	input  axi_pkg::axi_addr_t      inst_ar_i,
	input  wire logic               inst_ar_valid_i,
	output logic                    inst_ar_ready_o,
	output axi_pkg::axi_rdata_t     inst_r_o,
	output logic                    inst_r_valid_o,
	input  wire logic               inst_r_ready_i,

	// data master
	input  axi_pkg::axi_addr_t      data_ar_i,
	input  wire logic               data_ar_valid_i,
	output logic                    data_ar_ready_o,
	input  axi_pkg::axi_addr_t      data_aw_i,
	input  wire logic               data_aw_valid_i,
	output logic                    data_aw_ready_o,
	input  axi_pkg::axi_wdata_t     data_w_i,
	input  wire logic               data_w_valid_i,
	output logic                    data_w_ready_o,
	output axi_pkg::axi_rdata_t     data_r_o,
	output logic                    data_r_valid_o,
	input  wire logic               data_r_ready_i,
	output axi_pkg::axi_bresp_t     data_b_o,
	output logic                    data_b_valid_o,
	input  wire logic               data_b_ready_i,

	// memory slave
	output axi_pkg::axi_addr_t      mem_ar_o,
	output logic                    mem_ar_valid_o,
	input  wire logic               mem_ar_ready_i,
	output axi_pkg::axi_addr_t      mem_aw_o,
	output logic                    mem_aw_valid_o,
	input  wire logic               mem_aw_ready_i,
	output axi_pkg::axi_wdata_t     mem_w_o,
	output logic                    mem_w_valid_o,
	input  wire logic               mem_w_ready_i,
	input  axi_pkg::axi_rdata_t     mem_r_i,
	input  wire logic               mem_r_valid_i,
	output logic                    mem_r_ready_o,
	input  axi_pkg::axi_bresp_t     mem_b_i,
	input  wire logic               mem_b_valid_i,
	output logic                    mem_b_ready_o
);

	typedef enum logic [1:0] {
		ST_IDLE = 2'b00,
		ST_DATA = 2'b01, // data port owns the slave
		ST_INST = 2'b10  // instruction fetch owns the slave
	} grant_t;

	grant_t state_q;
	grant_t state_d;

	logic idle;
	logic sel_wr; // data write wins
	logic sel_rd; // data read wins
	logic sel_if; // instruction read wins
	logic acc_wr;
	logic acc_rd;
	logic acc_if;
	logic resp_done;

	assign idle = (state_q == ST_IDLE);

	// priority pick, only looked at while idle
	assign sel_wr = data_aw_valid_i & data_w_valid_i;
	assign sel_rd = ~sel_wr & data_ar_valid_i;
	assign sel_if = ~sel_wr & ~data_ar_valid_i & inst_ar_valid_i;

	assign acc_wr = idle & sel_wr & mem_aw_ready_i & mem_w_ready_i;
	assign acc_rd = idle & sel_rd & mem_ar_ready_i;
	assign acc_if = idle & sel_if & mem_ar_ready_i;

	// request side, winner only
	assign mem_ar_o       = sel_if ? inst_ar_i : data_ar_i;
	assign mem_ar_valid_o = idle & (sel_rd | sel_if);
	assign mem_aw_o       = data_aw_i;
	assign mem_aw_valid_o = idle & sel_wr;
	assign mem_w_o        = data_w_i;
	assign mem_w_valid_o  = idle & sel_wr;

	assign data_aw_ready_o = idle & sel_wr & mem_aw_ready_i & mem_w_ready_i;
	assign data_w_ready_o  = idle & sel_wr & mem_aw_ready_i & mem_w_ready_i;
	assign data_ar_ready_o = idle & sel_rd & mem_ar_ready_i;
	assign inst_ar_ready_o = idle & sel_if & mem_ar_ready_i;

	// response side, payloads pass straight through and valids are steered
	assign inst_r_o       = mem_r_i;
	assign inst_r_valid_o = (state_q == ST_INST) & mem_r_valid_i;
	assign data_r_o       = mem_r_i;
	assign data_r_valid_o = (state_q == ST_DATA) & mem_r_valid_i;
	assign data_b_o       = mem_b_i;
	assign data_b_valid_o = (state_q == ST_DATA) & mem_b_valid_i;

	always_comb begin
		case (state_q)
			ST_DATA: mem_r_ready_o = data_r_ready_i;
			ST_INST: mem_r_ready_o = inst_r_ready_i;
			default: mem_r_ready_o = 1'b0;
		endcase
	end

	assign mem_b_ready_o = (state_q == ST_DATA) & data_b_ready_i;

	// any response ends the grant, SLVERR included
	assign resp_done = (mem_r_valid_i & mem_r_ready_o) | (mem_b_valid_i & mem_b_ready_o);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (acc_wr | acc_rd)
					state_d = ST_DATA;
				else if (acc_if)
					state_d = ST_INST;
			end
			ST_DATA, ST_INST: begin
				if (resp_done)
					state_d = ST_IDLE;
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	// only one master may be offered the slave at a time
	a_one_ready: assert property (@(posedge clk) disable iff (rst)
		!(inst_ar_ready_o && (data_ar_ready_o || data_aw_ready_o)));

	a_one_addr: assert property (@(posedge clk) disable iff (rst)
		!(mem_ar_valid_o && mem_aw_valid_o));

endmodule

`default_nettype wire

//--- source/axi_pkg.sv
// shared widths, memory depth and response codes
// payload structs for the five AXI-lite channels

`default_nettype none

package axi_pkg;

	localparam int ADDR_W    = 32; // byte address
	localparam int DATA_W    = 32;
	localparam int STRB_W    = DATA_W / 8; // one strobe per byte
	localparam int MEM_DEPTH = 64; // words
	localparam int IDX_W     = $clog2(MEM_DEPTH);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// read address and write address channels
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} axi_addr_t;

	// write data channel
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axi_wdata_t;

	// read data channel
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
	} axi_rdata_t;

	// write response channel
	typedef struct packed {
		logic [1:0] resp;
	} axi_bresp_t;

endpackage

`default_nettype wire
